// ==== verilog.f ====
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_regfile.sv
logic/cpu_alu.sv
logic/cpu_lsu.sv
logic/cpu_core.sv
test/cpu_asserts.sv
test/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cpu_tb \
    -f verilog.f \
    -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int timeout_cycles = 2000;

    // LoongArch opcode bases with register and immediate fields zero
    localparam logic [31:0] add_op = 32'h0010_0000;
    localparam logic [31:0] sub_op = 32'h0011_0000;
    localparam logic [31:0] slt_op = 32'h0012_0000;
    localparam logic [31:0] sltu_op = 32'h0012_8000;
    localparam logic [31:0] nor_op = 32'h0014_0000;
    localparam logic [31:0] and_op = 32'h0014_8000;
    localparam logic [31:0] or_op = 32'h0015_0000;
    localparam logic [31:0] xor_op = 32'h0015_8000;
    localparam logic [31:0] slli_op = 32'h0040_8000;
    localparam logic [31:0] srli_op = 32'h0044_8000;
    localparam logic [31:0] srai_op = 32'h0048_8000;
    localparam logic [31:0] addi_op = 32'h0280_0000;
    localparam logic [31:0] lu12i_op = 32'h1400_0000;
    localparam logic [31:0] ld_op = 32'h2880_0000;
    localparam logic [31:0] st_op = 32'h2980_0000;
    localparam logic [31:0] jirl_op = 32'h4c00_0000;
    localparam logic [31:0] b_op = 32'h5000_0000;
    localparam logic [31:0] bl_op = 32'h5400_0000;
    localparam logic [31:0] beq_op = 32'h5800_0000;
    localparam logic [31:0] bne_op = 32'h5c00_0000;

    logic              clk;
    logic              reset;
    logic [31:0]       inst_addr;
    logic [31:0]       inst_rdata;
    cpu_pkg::apb_req_t apb;
    cpu_pkg::apb_rsp_t apb_rsp;
    cpu_pkg::trace_t   trace;

    logic [31:0]     imem [64];
    logic [31:0]     dmem [64];
    cpu_pkg::trace_t expected [$];
    int              seen;

    cpu_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .trace      (trace)
    );

    // rk slot also carries ui5 for the shifts
    function automatic logic [31:0] three_reg(input logic [31:0] base, input int rd,
                                              input int rj, input int rk);
        return {base[31:15], rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] reg_imm12(input logic [31:0] base, input int rd,
                                              input int rj, input int si12);
        return {base[31:22], si12[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] upper20(input logic [31:0] base, input int rd,
                                            input int si20);
        return {base[31:25], si20[19:0], rd[4:0]};
    endfunction

    // offsets in words
    function automatic logic [31:0] branch16(input logic [31:0] base, input int rd,
                                             input int rj, input int offs);
        return {base[31:26], offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] jump26(input logic [31:0] base, input int offs);
        return {base[31:26], offs[15:0], offs[25:16]};
    endfunction

    task automatic write_program();
        int i;
        for (i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
        end
        imem[0] = upper20(lu12i_op, 4, 32'h12345);
        imem[1] = reg_imm12(addi_op, 5, 0, 32'h678);
        imem[2] = three_reg(or_op, 6, 4, 5);
        imem[3] = reg_imm12(addi_op, 7, 0, -1);
        imem[4] = three_reg(add_op, 8, 6, 7);
        imem[5] = three_reg(sub_op, 9, 5, 6);
        imem[6] = three_reg(slt_op, 10, 9, 5);
        imem[7] = three_reg(sltu_op, 11, 9, 5);
        imem[8] = three_reg(and_op, 12, 6, 7);
        imem[9] = three_reg(nor_op, 13, 5, 0);
        imem[10] = three_reg(xor_op, 14, 6, 5);
        imem[11] = three_reg(slli_op, 15, 5, 4);
        imem[12] = three_reg(srli_op, 16, 9, 8);
        imem[13] = three_reg(srai_op, 17, 9, 8);
        // write to r0, then read r0 back
        imem[14] = reg_imm12(addi_op, 0, 6, 5);
        imem[15] = three_reg(add_op, 18, 0, 5);
        imem[16] = reg_imm12(addi_op, 19, 0, 32'h40);
        imem[17] = reg_imm12(st_op, 6, 19, 8);
        imem[18] = reg_imm12(ld_op, 20, 19, 8);
        imem[19] = reg_imm12(st_op, 9, 19, 12);
        imem[20] = reg_imm12(ld_op, 21, 19, 12);
        // r22 writes sit on paths that must be skipped
        imem[21] = branch16(beq_op, 6, 20, 2);
        imem[22] = reg_imm12(addi_op, 22, 0, 1);
        imem[23] = branch16(bne_op, 6, 20, 3);
        imem[24] = branch16(beq_op, 21, 20, 2);
        imem[25] = branch16(bne_op, 21, 20, 2);
        imem[26] = reg_imm12(addi_op, 22, 0, 2);
        imem[27] = jump26(bl_op, 3);
        imem[28] = reg_imm12(addi_op, 23, 0, 32'h77);
        imem[29] = jump26(b_op, 2);
        imem[30] = branch16(jirl_op, 24, 1, 0);
        imem[31] = three_reg(add_op, 25, 24, 23);
        imem[32] = jump26(b_op, 0);
    endtask

    task automatic expect_write(input logic [31:0] pc, input logic [4:0] wnum,
                                input logic [31:0] wdata);
        cpu_pkg::trace_t entry;
        entry.pc = pc;
        entry.we = 1'b1;
        entry.wnum = wnum;
        entry.wdata = wdata;
        expected.push_back(entry);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction memory answers one clock after the address
    initial begin
        inst_rdata = 32'h0;
        forever begin
            @(posedge clk);
            inst_rdata <= imem[inst_addr[7:2]];
        end
    end

    // apb completer with 0 to 3 wait cycles per transfer
    initial begin
        int i;
        int delay;
        int waits_left;
        void'($urandom(53752));
        apb_rsp = '0;
        waits_left = 0;
        for (i = 0; i < 64; i++) begin
            dmem[i] = 32'hc0de_0000 | i;
        end
        forever begin
            @(posedge clk);
            if (reset) begin
                apb_rsp <= '0;
            end else if (apb.psel && !apb.penable) begin
                delay = $urandom % 4;
                waits_left = delay;
                if (delay == 0) begin
                    apb_rsp.prdata <= dmem[apb.paddr[7:2]];
                    apb_rsp.pready <= 1'b1;
                end
            end else if (apb.psel && apb.penable && apb_rsp.pready) begin
                if (apb.pwrite) begin
                    dmem[apb.paddr[7:2]] <= apb.pwdata;
                end
                apb_rsp.pready <= 1'b0;
            end else if (apb.psel && apb.penable) begin
                if (waits_left <= 1) begin
                    apb_rsp.prdata <= dmem[apb.paddr[7:2]];
                    apb_rsp.pready <= 1'b1;
                end else begin
                    waits_left = waits_left - 1;
                end
            end
        end
    end

    // trace compare sampled mid-cycle
    initial begin
        seen = 0;
        forever begin
            @(negedge clk);
            if (!reset && trace.we) begin
                if (seen >= expected.size()) begin
                    $display("writeback at %0t after the last expected trace entry", $time);
                    $display("TESTS FAILED");
                    $fatal(1, "extra writeback");
                end else begin
                    assert (trace == expected[seen]) seen = seen + 1;
                    else begin
                        $display("ERROR %0t: entry %0d got pc %h r%0d %h, want pc %h r%0d %h",
                                 $time, seen, trace.pc, trace.wnum, trace.wdata,
                                 expected[seen].pc, expected[seen].wnum,
                                 expected[seen].wdata);
                        $display("TESTS FAILED");
                        $fatal(1, "trace mismatch");
                    end
                end
            end
        end
    end

    initial begin
        int cycles;
        reset = 1'b1;
        write_program();
        expect_write(32'h1c00_0000, 5'd4, 32'h1234_5000);
        expect_write(32'h1c00_0004, 5'd5, 32'h0000_0678);
        expect_write(32'h1c00_0008, 5'd6, 32'h1234_5678);
        expect_write(32'h1c00_000c, 5'd7, 32'hffff_ffff);
        expect_write(32'h1c00_0010, 5'd8, 32'h1234_5677);
        expect_write(32'h1c00_0014, 5'd9, 32'hedcb_b000);
        expect_write(32'h1c00_0018, 5'd10, 32'h0000_0001);
        expect_write(32'h1c00_001c, 5'd11, 32'h0000_0000);
        expect_write(32'h1c00_0020, 5'd12, 32'h1234_5678);
        expect_write(32'h1c00_0024, 5'd13, 32'hffff_f987);
        expect_write(32'h1c00_0028, 5'd14, 32'h1234_5000);
        expect_write(32'h1c00_002c, 5'd15, 32'h0000_6780);
        expect_write(32'h1c00_0030, 5'd16, 32'h00ed_cbb0);
        expect_write(32'h1c00_0034, 5'd17, 32'hffed_cbb0);
        expect_write(32'h1c00_003c, 5'd18, 32'h0000_0678);
        expect_write(32'h1c00_0040, 5'd19, 32'h0000_0040);
        expect_write(32'h1c00_0048, 5'd20, 32'h1234_5678);
        expect_write(32'h1c00_0050, 5'd21, 32'hedcb_b000);
        expect_write(32'h1c00_006c, 5'd1, 32'h1c00_0070);
        expect_write(32'h1c00_0078, 5'd24, 32'h1c00_007c);
        expect_write(32'h1c00_0070, 5'd23, 32'h0000_0077);
        expect_write(32'h1c00_007c, 5'd25, 32'h1c00_00f3);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (seen < expected.size() && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        // self loop keeps running so a late writeback still gets caught
        repeat (40) @(posedge clk);
        if (seen != expected.size()) begin
            $display("program did not finish within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "timeout waiting for the trace");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/cpu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
    input wire                    clk,
    input wire                    reset,
    input wire [31:0]             inst_addr,
    input wire cpu_pkg::apb_req_t apb,
    input wire cpu_pkg::apb_rsp_t apb_rsp,
    input wire cpu_pkg::trace_t   trace,
    input wire cpu_pkg::stage_e   stage
);

    setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(apb.psel) |-> !apb.penable)
        else $error("psel rose with penable already high");

    access_follows: assert property (@(posedge clk) disable iff (reset)
        apb.psel && !apb.penable |=> apb.psel && apb.penable)
        else $error("penable did not follow the setup cycle");

    // covers setup to access and every wait cycle
    request_held: assert property (@(posedge clk) disable iff (reset)
        apb.psel && !(apb.penable && apb_rsp.pready)
        |=> $stable(apb.paddr) && $stable(apb.pwrite) && $stable(apb.pwdata))
        else $error("apb request changed before pready");

    release_after_ready: assert property (@(posedge clk) disable iff (reset)
        apb.psel && apb.penable && apb_rsp.pready |=> !apb.psel && !apb.penable)
        else $error("psel or penable still high after the pready cycle");

    psel_in_mem: assert property (@(posedge clk) disable iff (reset)
        apb.psel |-> stage == cpu_pkg::st_mem)
        else $error("psel high with no load or store in flight");

    trace_not_r0: assert property (@(posedge clk) disable iff (reset)
        trace.we |-> trace.wnum != 5'd0)
        else $error("trace write to r0");

    // during reset and the first cycle after it
    quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !apb.psel && !apb.penable && !trace.we)
        else $error("bus or trace active around reset");

    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> inst_addr == cpu_pkg::reset_pc)
        else $error("first fetch not at the reset pc");

endmodule

bind cpu_core cpu_asserts asserts0 (
    .clk       (clk),
    .reset     (reset),
    .inst_addr (inst_addr),
    .apb       (apb),
    .apb_rsp   (apb_rsp),
    .trace     (trace),
    .stage     (stage)
);

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                    clk,
    input  wire                    reset,
    output logic [31:0]            inst_addr,
    input  wire [31:0]             inst_rdata,
    output cpu_pkg::apb_req_t      apb,
    input  wire cpu_pkg::apb_rsp_t apb_rsp,
    output cpu_pkg::trace_t        trace
);

    cpu_pkg::stage_e stage;
    cpu_pkg::stage_e stage_nxt;
    cpu_pkg::dec_t   dec_w;
    cpu_pkg::dec_t   ir;
    logic [31:0]     pc;
    logic [31:0]     npc;
    logic [31:0]     rj_value;
    logic [31:0]     rkd_value;
    logic [31:0]     alu_src1;
    logic [31:0]     alu_src2;
    logic [31:0]     alu_result;
    logic [31:0]     br_target;
    logic [31:0]     exe_next_pc;
    logic [31:0]     result_q;
    logic [31:0]     load_data;
    logic [31:0]     rf_wdata;
    logic            br_taken;
    logic            lsu_start;
    logic            lsu_done;
    logic            wb_we;

    // instruction memory answers one cycle after the address
    assign inst_addr = pc;

    always_comb begin
        case (stage)
            cpu_pkg::st_if:  stage_nxt = cpu_pkg::st_id;
            cpu_pkg::st_id:  stage_nxt = cpu_pkg::st_exe;
            cpu_pkg::st_exe: begin
                if (ir.mem_kind != cpu_pkg::mem_none) stage_nxt = cpu_pkg::st_mem;
                else if (ir.rf_we) stage_nxt = cpu_pkg::st_wb;
                else stage_nxt = cpu_pkg::st_if;
            end
            // wait here for the apb completer
            cpu_pkg::st_mem: begin
                if (!lsu_done) stage_nxt = cpu_pkg::st_mem;
                else if (ir.rf_we) stage_nxt = cpu_pkg::st_wb;
                else stage_nxt = cpu_pkg::st_if;
            end
            default:         stage_nxt = cpu_pkg::st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= cpu_pkg::st_if;
            pc <= cpu_pkg::reset_pc;
        end else begin
            stage <= stage_nxt;
            if (stage != cpu_pkg::st_if && stage_nxt == cpu_pkg::st_if) begin
                pc <= (stage == cpu_pkg::st_exe) ? exe_next_pc : npc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage == cpu_pkg::st_id) begin
            ir <= dec_w;
        end
        if (stage == cpu_pkg::st_exe) begin
            result_q <= alu_result;
            npc <= exe_next_pc;
        end
    end

    cpu_decode u_decode (
        .inst (inst_rdata),
        .dec  (dec_w)
    );

    cpu_regfile u_regfile (
        .clk    (clk),
        .raddr1 (ir.rj),
        .rdata1 (rj_value),
        .raddr2 (ir.rkd_addr),
        .rdata2 (rkd_value),
        .we     (wb_we),
        .waddr  (ir.dest),
        .wdata  (rf_wdata)
    );

    assign alu_src1 = ir.src1_is_pc ? pc : rj_value;
    assign alu_src2 = ir.src2_is_imm ? ir.imm : rkd_value;

    cpu_alu u_alu (
        .op        (ir.alu_op),
        .src1      (alu_src1),
        .src2      (alu_src2),
        .br_kind   (ir.br_kind),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (pc),
        .br_offs   (ir.br_offs),
        .result    (alu_result),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    assign exe_next_pc = br_taken ? br_target : pc + 32'd4;

    // issued in st_exe so setup lands in the first st_mem cycle
    assign lsu_start = (stage == cpu_pkg::st_exe) && (ir.mem_kind != cpu_pkg::mem_none);

    cpu_lsu u_lsu (
        .clk       (clk),
        .reset     (reset),
        .start     (lsu_start),
        .kind      (ir.mem_kind),
        .addr      (alu_result),
        .wdata     (rkd_value),
        .apb       (apb),
        .apb_rsp   (apb_rsp),
        .done      (lsu_done),
        .load_data (load_data)
    );

    // writeback
    assign wb_we = (stage == cpu_pkg::st_wb);
    assign rf_wdata = (ir.mem_kind == cpu_pkg::mem_load) ? load_data : result_q;

    assign trace = '{pc: pc, we: wb_we, wnum: ir.dest, wdata: rf_wdata};

endmodule

`default_nettype wire

// ==== logic/cpu_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_lsu (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire cpu_pkg::mem_kind_e kind,
    input  wire [31:0]              addr,
    input  wire [31:0]              wdata,
    output cpu_pkg::apb_req_t       apb,
    input  wire cpu_pkg::apb_rsp_t  apb_rsp,
    output logic                    done,
    output logic [31:0]             load_data
);

    typedef enum logic [1:0] {
        ls_idle,
        ls_setup,
        ls_access
    } lsu_state_e;

    lsu_state_e  state;
    logic [31:0] paddr_q;
    logic [31:0] pwdata_q;
    logic        pwrite_q;
    logic        xfer_end;

    assign xfer_end = (state == ls_access) && apb_rsp.pready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ls_idle;
            done <= 1'b0;
        end else begin
            done <= xfer_end;
            case (state)
                ls_idle:   if (start && kind != cpu_pkg::mem_none) state <= ls_setup;
                ls_setup:  state <= ls_access;
                ls_access: if (apb_rsp.pready) state <= ls_idle;
                default:   state <= ls_idle;
            endcase
        end
    end

    // request held from start until the pready cycle
    always_ff @(posedge clk) begin
        if (state == ls_idle && start) begin
            paddr_q <= addr;
            pwdata_q <= wdata;
            pwrite_q <= (kind == cpu_pkg::mem_store);
        end
        if (xfer_end && !pwrite_q) begin
            load_data <= apb_rsp.prdata;
        end
    end

    assign apb = '{paddr: paddr_q, psel: (state != ls_idle), penable: (state == ls_access),
                   pwrite: pwrite_q, pwdata: pwdata_q};

endmodule

`default_nettype wire

// ==== logic/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  wire cpu_pkg::alu_op_e  op,
    input  wire [31:0]             src1,
    input  wire [31:0]             src2,
    input  wire cpu_pkg::br_kind_e br_kind,
    input  wire [31:0]             rj_value,
    input  wire [31:0]             rkd_value,
    input  wire [31:0]             pc,
    input  wire [31:0]             br_offs,
    output logic [31:0]            result,
    output logic                   br_taken,
    output logic [31:0]            br_target
);

    logic [4:0] shamt;
    logic       rj_eq_rkd;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            cpu_pkg::op_add:  result = src1 + src2;
            cpu_pkg::op_sub:  result = src1 - src2;
            cpu_pkg::op_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            cpu_pkg::op_sltu: result = {31'b0, src1 < src2};
            cpu_pkg::op_and:  result = src1 & src2;
            cpu_pkg::op_nor:  result = ~(src1 | src2);
            cpu_pkg::op_or:   result = src1 | src2;
            cpu_pkg::op_xor:  result = src1 ^ src2;
            cpu_pkg::op_sll:  result = src1 << shamt;
            cpu_pkg::op_srl:  result = src1 >> shamt;
            cpu_pkg::op_sra:  result = $unsigned($signed(src1) >>> shamt);
            // imm already shifted by decode
            cpu_pkg::op_lui:  result = src2;
            default:          result = src1 + src2;
        endcase
    end

    assign rj_eq_rkd = (rj_value == rkd_value);

    always_comb begin
        case (br_kind)
            cpu_pkg::br_b,
            cpu_pkg::br_bl,
            cpu_pkg::br_jirl: br_taken = 1'b1;
            cpu_pkg::br_beq:  br_taken = rj_eq_rkd;
            cpu_pkg::br_bne:  br_taken = !rj_eq_rkd;
            default:          br_taken = 1'b0;
        endcase
    end

    // jirl is register relative and the rest pc relative
    assign br_target = ((br_kind == cpu_pkg::br_jirl) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

// ==== logic/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  wire        clk,
    input  wire [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  wire [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  wire        we,
    input  wire [4:0]  waddr,
    input  wire [31:0] wdata
);

    logic [31:0] regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  wire [31:0]    inst,
    output cpu_pkg::dec_t dec
);

    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [31:0] imm_ui5;
    logic [31:0] imm_si12;
    logic [31:0] imm_si20;
    logic [31:0] offs_si16;
    logic [31:0] offs_si26;
    logic        writes_rd;
    logic        rd_is_src;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign imm_ui5   = {27'b0, inst[14:10]};
    assign imm_si12  = {{20{inst[21]}}, inst[21:10]};
    assign imm_si20  = {inst[24:5], 12'b0};
    assign offs_si16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    // si26 is split with the high half in the low bits
    assign offs_si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    always_comb begin
        dec = '0;
        dec.alu_op = cpu_pkg::op_add;
        dec.br_kind = cpu_pkg::br_none;
        dec.mem_kind = cpu_pkg::mem_none;
        writes_rd = 1'b0;
        rd_is_src = 1'b0;
        casez (inst[31:15])
            // 3R group
            17'b000000_0000_01_?????: begin
                writes_rd = 1'b1;
                case (inst[19:15])
                    5'h00:   dec.alu_op = cpu_pkg::op_add;
                    5'h02:   dec.alu_op = cpu_pkg::op_sub;
                    5'h04:   dec.alu_op = cpu_pkg::op_slt;
                    5'h05:   dec.alu_op = cpu_pkg::op_sltu;
                    5'h08:   dec.alu_op = cpu_pkg::op_nor;
                    5'h09:   dec.alu_op = cpu_pkg::op_and;
                    5'h0a:   dec.alu_op = cpu_pkg::op_or;
                    5'h0b:   dec.alu_op = cpu_pkg::op_xor;
                    default: writes_rd = 1'b0;
                endcase
            end
            // shift by ui5
            17'b000000_0001_00_?????: begin
                writes_rd = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm = imm_ui5;
                case (inst[19:15])
                    5'h01:   dec.alu_op = cpu_pkg::op_sll;
                    5'h09:   dec.alu_op = cpu_pkg::op_srl;
                    5'h11:   dec.alu_op = cpu_pkg::op_sra;
                    default: writes_rd = 1'b0;
                endcase
            end
            17'b000000_1010_???????: begin
                writes_rd = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm = imm_si12;
            end
            17'b000101_0??????????: begin
                writes_rd = 1'b1;
                dec.alu_op = cpu_pkg::op_lui;
                dec.src2_is_imm = 1'b1;
                dec.imm = imm_si20;
            end
            17'b001010_0010_???????: begin
                writes_rd = 1'b1;
                dec.mem_kind = cpu_pkg::mem_load;
                dec.src2_is_imm = 1'b1;
                dec.imm = imm_si12;
            end
            17'b001010_0110_???????: begin
                rd_is_src = 1'b1;
                dec.mem_kind = cpu_pkg::mem_store;
                dec.src2_is_imm = 1'b1;
                dec.imm = imm_si12;
            end
            // link value is pc + 4 through the alu
            17'b010011_???????????: begin
                writes_rd = 1'b1;
                dec.br_kind = cpu_pkg::br_jirl;
                dec.src1_is_pc = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm = 32'd4;
                dec.br_offs = offs_si16;
            end
            17'b010100_???????????: begin
                dec.br_kind = cpu_pkg::br_b;
                dec.br_offs = offs_si26;
            end
            17'b010101_???????????: begin
                writes_rd = 1'b1;
                dec.br_kind = cpu_pkg::br_bl;
                dec.src1_is_pc = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm = 32'd4;
                dec.br_offs = offs_si26;
            end
            17'b010110_???????????: begin
                rd_is_src = 1'b1;
                dec.br_kind = cpu_pkg::br_beq;
                dec.br_offs = offs_si16;
            end
            17'b010111_???????????: begin
                rd_is_src = 1'b1;
                dec.br_kind = cpu_pkg::br_bne;
                dec.br_offs = offs_si16;
            end
            default: ;
        endcase
        dec.rj = rj;
        dec.rkd_addr = rd_is_src ? rd : rk;
        dec.dest = (dec.br_kind == cpu_pkg::br_bl) ? 5'd1 : rd;
        dec.rf_we = writes_rd && (dec.dest != 5'd0);
    end

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } stage_e;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_nor,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_b,
        br_bl,
        br_beq,
        br_bne,
        br_jirl
    } br_kind_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        br_kind_e    br_kind;
        mem_kind_e   mem_kind;
        logic        src1_is_pc;
        logic        src2_is_imm;
        // already low when dest is r0
        logic        rf_we;
        logic [4:0]  rj;
        logic [4:0]  rkd_addr;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [31:0] br_offs;
    } dec_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage

`default_nettype wire
